// File: synth_pkg.sv
package synth_pkg;

    typedef logic [2:0] note_idx_t;        // 0..6 = C D E F G A B

    typedef struct packed {
        logic      active;
        note_idx_t note;
        logic [2:0] octave;
    } note_cmd_t;

    typedef struct packed {
        logic signed [15:0] left;          // sent first on the serial line
        logic signed [15:0] right;
    } audio_sample_t;

    localparam logic [2:0] OCT_MIN   = 3'd3;
    localparam logic [2:0] OCT_MAX   = 3'd5;
    localparam logic [2:0] OCT_RESET = 3'd4;
    localparam logic [2:0] VOL_MIN   = 3'd1;
    localparam logic [2:0] VOL_MAX   = 3'd5;
    localparam logic [2:0] VOL_RESET = 3'd3;

    localparam logic [7:0] BREAK_CODE = 8'hF0;

    // set-2 scan codes of the a..j row, returns 1 on a known key
    function automatic logic key_to_note(input logic [7:0] code, output note_idx_t note);
        logic hit;
        hit = 1'b1;
        case (code)
            8'h1C:   note = 3'd0;          // a -> C
            8'h1B:   note = 3'd1;          // s -> D
            8'h23:   note = 3'd2;          // d -> E
            8'h2B:   note = 3'd3;          // f -> F
            8'h34:   note = 3'd4;          // g -> G
            8'h33:   note = 3'd5;          // h -> A
            8'h3B:   note = 3'd6;          // j -> B
            default: begin
                note = 3'd0;
                hit  = 1'b0;
            end
        endcase
        return hit;
    endfunction

    // clock cycles per half wave, octave 4 is the base table
    function automatic logic [31:0] half_period(input logic [31:0] clk_hz,
                                                input note_idx_t note,
                                                input logic [2:0] octave);
        logic [31:0] freq;
        logic [31:0] cycles;
        case (note)
            3'd0:    freq = 32'd262;
            3'd1:    freq = 32'd294;
            3'd2:    freq = 32'd330;
            3'd3:    freq = 32'd350;
            3'd4:    freq = 32'd392;
            3'd5:    freq = 32'd440;
            default: freq = 32'd494;
        endcase
        cycles = clk_hz / (freq << 1);
        if (octave > 3'd4) begin
            cycles = cycles >> (octave - 3'd4);
        end else begin
            cycles = cycles << (3'd4 - octave);
        end
        if (cycles == 32'd0) begin
            cycles = 32'd1;                // never let the counter reload below one
        end
        return cycles;
    endfunction

    function automatic logic [15:0] amplitude(input logic [2:0] volume);
        case (volume)
            3'd1:    return 16'd1024;
            3'd2:    return 16'd2048;
            3'd3:    return 16'd4096;
            3'd4:    return 16'd8192;
            default: return 16'd16384;
        endcase
    endfunction

endpackage

// File: key_mapper.sv
`timescale 1ns/1ps

module key_mapper (
    input  logic                  clk,
    input  logic                  out_rst,
    input  logic [7:0]            scan_code,
    input  logic                  scan_valid,
    input  logic [2:0]            octave,
    output synth_pkg::note_cmd_t  note_cmd
);

    logic                 break_pending;   // last byte was F0
    logic                 active;
    synth_pkg::note_idx_t held_note;
    synth_pkg::note_idx_t key_note;
    logic                 key_valid;

    always_comb begin
        key_valid = synth_pkg::key_to_note(scan_code, key_note);
    end

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            break_pending <= 1'b0;
            active        <= 1'b0;
            held_note     <= '0;
        end else if (scan_valid) begin
            if (scan_code == synth_pkg::BREAK_CODE) begin
                break_pending <= 1'b1;
            end else begin
                break_pending <= 1'b0;      // prefix only covers the next byte
                if (key_valid) begin
                    if (break_pending) begin
                        // release only if it is the key we are sounding
                        if (active && (key_note == held_note)) begin
                            active <= 1'b0;
                        end
                    end else begin
                        active    <= 1'b1;
                        held_note <= key_note;
                    end
                end
            end
        end
    end

    // octave tracks the live level so a held note retunes
    always_comb begin
        note_cmd.active = active;
        note_cmd.note   = held_note;
        note_cmd.octave = octave;
    end

    a_note_in_range: assert property (
        @(posedge clk) disable iff (out_rst)
        note_cmd.active |-> (note_cmd.note <= 3'd6)
    ) else $error("key_mapper: active note index out of range");

endmodule

// File: tone_control.sv
`timescale 1ns/1ps

module tone_control (
    input  logic       clk,
    input  logic       out_rst,
    input  logic       vol_up,
    input  logic       vol_down,
    input  logic       oct_up,
    input  logic       oct_down,
    output logic [2:0] octave,
    output logic [2:0] volume,
    output logic [4:0] led
);

    logic [2:0] vol_next;
    logic [2:0] oct_next;

    // saturating steps, up wins over down
    always_comb begin
        vol_next = volume;
        if (vol_up && (volume < synth_pkg::VOL_MAX)) begin
            vol_next = volume + 3'd1;
        end else if (!vol_up && vol_down && (volume > synth_pkg::VOL_MIN)) begin
            vol_next = volume - 3'd1;
        end
        oct_next = octave;
        if (oct_up && (octave < synth_pkg::OCT_MAX)) begin
            oct_next = octave + 3'd1;
        end else if (!oct_up && oct_down && (octave > synth_pkg::OCT_MIN)) begin
            oct_next = octave - 3'd1;
        end
    end

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            octave <= synth_pkg::OCT_RESET;
            volume <= synth_pkg::VOL_RESET;
            led    <= 5'b00111;
        end else begin
            octave <= oct_next;
            volume <= vol_next;
            for (int i = 0; i < 5; i++) begin
                led[i] <= (i < int'(vol_next)); // thermometer, updates with volume
            end
        end
    end

    a_oct_range: assert property (
        @(posedge clk) disable iff (out_rst)
        (octave >= synth_pkg::OCT_MIN) && (octave <= synth_pkg::OCT_MAX)
    ) else $error("tone_control: octave out of range");

    a_vol_range: assert property (
        @(posedge clk) disable iff (out_rst)
        (volume >= synth_pkg::VOL_MIN) && (volume <= synth_pkg::VOL_MAX)
    ) else $error("tone_control: volume out of range");

endmodule

// File: note_gen.sv
`timescale 1ns/1ps

module note_gen #(
    parameter int unsigned CLK_HZ = 100_000_000
) (
    input  logic                     clk,
    input  logic                     out_rst,
    input  synth_pkg::note_cmd_t     note_cmd,
    input  logic [2:0]               volume,
    output synth_pkg::audio_sample_t sample
);

    synth_pkg::note_cmd_t cmd_q;           // last command seen
    logic [31:0]          half_cnt;
    logic [31:0]          reload;
    logic                 phase;           // 1 = positive half
    logic signed [15:0]   amp;
    logic signed [15:0]   level;

    always_comb begin
        reload = synth_pkg::half_period(32'(CLK_HZ), note_cmd.note, note_cmd.octave) - 32'd1;
    end

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            cmd_q    <= '0;
            half_cnt <= '0;
            phase    <= 1'b1;
        end else begin
            cmd_q <= note_cmd;
            if (note_cmd != cmd_q) begin
                half_cnt <= reload;        // restart wave on any command change
                phase    <= 1'b1;
            end else if (half_cnt == 32'd0) begin
                half_cnt <= reload;
                phase    <= ~phase;
            end else begin
                half_cnt <= half_cnt - 32'd1;
            end
        end
    end

    always_comb begin
        amp = $signed(synth_pkg::amplitude(volume));
        if (!cmd_q.active) begin
            level = 16'sd0;                // silence
        end else if (phase) begin
            level = amp;
        end else begin
            level = -amp;
        end
        sample.left  = level;
        sample.right = level;              // mono on both channels
    end

endmodule

// File: speaker_control.sv
`timescale 1ns/1ps

module speaker_control (
    input  logic                     clk,
    input  logic                     out_rst,
    input  synth_pkg::audio_sample_t sample,
    output logic                     audio_mclk,
    output logic                     audio_lrck,
    output logic                     audio_sck,
    output logic                     audio_sdin
);

    // frame_cnt layout
    //   [0]   mclk, clk / 2
    //   [1]   sck, clk / 4
    //   [5:2] bit slot inside the word
    //   [6]   lrck, low = left word
    logic [6:0]  frame_cnt;
    logic [31:0] shift_q;                  // left word in the upper half
    logic        frame_end;
    logic        sck_fall;

    assign frame_end = (frame_cnt == 7'h7f);
    assign sck_fall  = (frame_cnt[1:0] == 2'b11);

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            frame_cnt <= '0;
            shift_q   <= '0;
        end else begin
            frame_cnt <= frame_cnt + 7'd1;
            if (frame_end) begin
                shift_q <= sample;         // capture as lrck falls
            end else if (sck_fall) begin
                shift_q <= {shift_q[30:0], 1'b0};
            end
        end
    end

    assign audio_mclk = frame_cnt[0];
    assign audio_sck  = frame_cnt[1];
    assign audio_lrck = frame_cnt[6];
    assign audio_sdin = shift_q[31];       // msb first

    // one lrck level per 16 bit slots
    a_lrck_on_wrap: assert property (
        @(posedge clk) disable iff (out_rst)
        $changed(audio_lrck) |-> ($past(frame_cnt[5:0]) == 6'h3f)
    ) else $error("speaker_control: lrck moved inside a word");

    // data only moves while sck is low
    a_sdin_stable: assert property (
        @(posedge clk) disable iff (out_rst)
        $changed(audio_sdin) |-> !audio_sck
    ) else $error("speaker_control: sdin changed while sck high");

endmodule

// File: seven_segment.sv
`timescale 1ns/1ps

module seven_segment #(
    parameter int SCAN_DIGIT_BITS = 18
) (
    input  logic                 clk,
    input  logic                 out_rst,
    input  synth_pkg::note_cmd_t note_cmd,
    output logic [6:0]           display,
    output logic [3:0]           digit
);

    localparam logic [6:0] SEG_BLANK = 7'b1111111;

    logic [SCAN_DIGIT_BITS-1:0] refresh_cnt;
    logic [1:0]                 sel;
    logic [6:0]                 seg_next;
    logic [3:0]                 digit_next;

    // segments are {g,f,e,d,c,b,a}, active low
    function automatic logic [6:0] letter_seg(input synth_pkg::note_idx_t note);
        case (note)
            3'd0:    return 7'b1000110;   // C
            3'd1:    return 7'b0100001;   // d
            3'd2:    return 7'b0000110;   // E
            3'd3:    return 7'b0001110;   // F
            3'd4:    return 7'b0010000;   // g
            3'd5:    return 7'b0001000;   // A
            3'd6:    return 7'b0000011;   // b
            default: return SEG_BLANK;
        endcase
    endfunction

    function automatic logic [6:0] octave_seg(input logic [2:0] octave);
        case (octave)
            3'd3:    return 7'b0110000;
            3'd4:    return 7'b0011001;
            3'd5:    return 7'b0010010;
            default: return 7'b0111111;   // dash
        endcase
    endfunction

    assign sel = refresh_cnt[SCAN_DIGIT_BITS-1 -: 2];

    always_comb begin
        digit_next = ~(4'b0001 << sel);
        case (sel)
            2'd0:    seg_next = octave_seg(note_cmd.octave);
            2'd1:    seg_next = letter_seg(note_cmd.note);
            default: seg_next = SEG_BLANK;
        endcase
        if (!note_cmd.active) begin
            digit_next = 4'b1111;          // whole display dark
            seg_next   = SEG_BLANK;
        end
    end

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            refresh_cnt <= '0;
            display     <= SEG_BLANK;
            digit       <= 4'b1111;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
            display     <= seg_next;
            digit       <= digit_next;
        end
    end

endmodule

// File: music_keyboard_top.sv
`timescale 1ns/1ps

module music_keyboard_top #(
    parameter int unsigned CLK_HZ          = 100_000_000,
    parameter int          SCAN_DIGIT_BITS = 18
) (
    input  logic       clk,
    input  logic       out_rst,
    input  logic [7:0] scan_code,
    input  logic       scan_valid,
    input  logic       vol_up,
    input  logic       vol_down,
    input  logic       oct_up,
    input  logic       oct_down,
    output logic [4:0] led,
    output logic [6:0] display,
    output logic [3:0] digit,
    output logic       audio_mclk,
    output logic       audio_lrck,
    output logic       audio_sck,
    output logic       audio_sdin
);

    synth_pkg::note_cmd_t     note_cmd;
    synth_pkg::audio_sample_t sample;
    logic [2:0]               octave;
    logic [2:0]               volume;

    key_mapper key_mapper_i (
        .clk        (clk),
        .out_rst    (out_rst),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .octave     (octave),
        .note_cmd   (note_cmd)
    );

    tone_control tone_control_i (
        .clk      (clk),
        .out_rst  (out_rst),
        .vol_up   (vol_up),
        .vol_down (vol_down),
        .oct_up   (oct_up),
        .oct_down (oct_down),
        .octave   (octave),
        .volume   (volume),
        .led      (led)
    );

    note_gen #(
        .CLK_HZ (CLK_HZ)
    ) note_gen_i (
        .clk      (clk),
        .out_rst  (out_rst),
        .note_cmd (note_cmd),
        .volume   (volume),
        .sample   (sample)
    );

    speaker_control speaker_control_i (
        .clk        (clk),
        .out_rst    (out_rst),
        .sample     (sample),
        .audio_mclk (audio_mclk),
        .audio_lrck (audio_lrck),
        .audio_sck  (audio_sck),
        .audio_sdin (audio_sdin)
    );

    seven_segment #(
        .SCAN_DIGIT_BITS (SCAN_DIGIT_BITS)
    ) seven_segment_i (
        .clk      (clk),
        .out_rst  (out_rst),
        .note_cmd (note_cmd),
        .display  (display),
        .digit    (digit)
    );

endmodule

// File: tb_music_keyboard.sv
`timescale 1ns/1ps

module tb_music_keyboard;

    localparam int unsigned CLK_HZ  = 200000;
    localparam int TIMEOUT_CYCLES   = 60000;   // about three times the full sequence
    localparam int PITCH_FRAMES     = 32;
    localparam int FRAME_CLKS       = 128;     // 32 sck of 4 clocks each

    typedef struct packed {
        logic [6:0] display;
        logic [3:0] digit;
    } seg_view_t;

    logic       clk;
    logic       out_rst;
    logic [7:0] scan_code;
    logic       scan_valid;
    logic       vol_up;
    logic       vol_down;
    logic       oct_up;
    logic       oct_down;
    logic [4:0] led;
    logic [6:0] display;
    logic [3:0] digit;
    logic       audio_mclk;
    logic       audio_lrck;
    logic       audio_sck;
    logic       audio_sdin;

    logic       ref_active;                // model of the keyboard state
    logic [2:0] ref_note;
    logic       ref_break;
    logic [2:0] ref_oct;
    logic [2:0] ref_vol;

    int          cycle_count;
    int          frame_count;
    int          change_frame;             // frame index at the last input change
    int          sck_edges;
    int          last_edges;
    int          sign_changes;
    logic        pos_seen;
    logic        neg_seen;
    logic        prev_settled;
    logic signed [15:0] prev_level;
    logic [31:0] rx_shift;
    logic        mclk_prev;
    logic        rst_prev;
    int          led_errors;
    int          sample_errors;
    int          segment_errors;
    int          other_errors;

    music_keyboard_top #(
        .CLK_HZ          (CLK_HZ),
        .SCAN_DIGIT_BITS (4)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] code_of(input logic [2:0] note);
        case (note)
            3'd0:    return 8'h1C;
            3'd1:    return 8'h1B;
            3'd2:    return 8'h23;
            3'd3:    return 8'h2B;
            3'd4:    return 8'h34;
            3'd5:    return 8'h33;
            default: return 8'h3B;
        endcase
    endfunction

    function automatic logic is_key(input logic [7:0] code, output logic [2:0] note);
        note = 3'd0;
        for (int i = 0; i < 7; i++) begin
            if (code_of(3'(i)) == code) begin
                note = 3'(i);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic synth_pkg::note_cmd_t expected_cmd();
        synth_pkg::note_cmd_t cmd;
        cmd.active = ref_active;
        cmd.note   = ref_note;
        cmd.octave = ref_oct;
        return cmd;
    endfunction

    function automatic logic [15:0] expected_magnitude(input logic [2:0] vol);
        return 16'd1024 << (vol - 3'd1);   // doubles per step
    endfunction

    function automatic logic [4:0] expected_led(input logic [2:0] vol);
        return 5'b11111 >> (3'd5 - vol);
    endfunction

    function automatic int expected_half_period(input logic [2:0] note, input logic [2:0] oct);
        int freq;
        int cycles;
        case (note)
            3'd0:    freq = 262;
            3'd1:    freq = 294;
            3'd2:    freq = 330;
            3'd3:    freq = 350;
            3'd4:    freq = 392;
            3'd5:    freq = 440;
            default: freq = 494;
        endcase
        cycles = int'(CLK_HZ) / (2 * freq);
        if (oct >= 3'd4) begin
            cycles = cycles >> (oct - 3'd4);
        end else begin
            cycles = cycles << (3'd4 - oct);
        end
        return cycles;
    endfunction

    // segment order g f e d c b a, active low
    function automatic logic [6:0] letter_pattern(input logic [2:0] note);
        case (note)
            3'd0:    return 7'b1000110;
            3'd1:    return 7'b0100001;
            3'd2:    return 7'b0000110;
            3'd3:    return 7'b0001110;
            3'd4:    return 7'b0010000;
            3'd5:    return 7'b0001000;
            default: return 7'b0000011;
        endcase
    endfunction

    function automatic logic [6:0] number_pattern(input logic [2:0] oct);
        case (oct)
            3'd3:    return 7'b0110000;
            3'd4:    return 7'b0011001;
            default: return 7'b0010010;
        endcase
    endfunction

    function automatic seg_view_t expected_segments(input synth_pkg::note_cmd_t cmd,
                                                    input logic [3:0] sel);
        seg_view_t view;
        view.digit   = sel;
        view.display = 7'h7f;
        if (!cmd.active) begin
            view.digit = 4'hf;
        end else begin
            case (sel)
                4'b1110:          view.display = number_pattern(cmd.octave);
                4'b1101:          view.display = letter_pattern(cmd.note);
                4'b1011, 4'b0111: view.display = 7'h7f;
                default:          view.digit   = 4'b1110; // no single digit selected
            endcase
        end
        return view;
    endfunction

    task automatic check_led(input logic [4:0] got, input logic [4:0] want);
        if (got !== want) begin
            led_errors++;
            $display("[ERROR] %0t: led got %b expected %b", $time, got, want);
        end
    endtask

    task automatic check_sample(input synth_pkg::audio_sample_t got,
                                input synth_pkg::audio_sample_t want);
        if (got !== want) begin
            sample_errors++;
            $display("[ERROR] %0t: frame got %0d/%0d expected %0d/%0d", $time,
                     got.left, got.right, want.left, want.right);
        end
    endtask

    task automatic check_segments(input seg_view_t got, input seg_view_t want);
        if (got !== want) begin
            segment_errors++;
            $display("[ERROR] %0t: display/digit got %b/%b expected %b/%b", $time,
                     got.display, got.digit, want.display, want.digit);
        end
    endtask

    // mclk is half the clock rate once reset is gone
    always @(negedge clk) begin
        if (!out_rst && !rst_prev && (audio_mclk === mclk_prev)) begin
            other_errors++;
            $display("[ERROR] %0t: audio_mclk stayed %b for two clock cycles",
                     $time, audio_mclk);
        end
        mclk_prev = audio_mclk;
        rst_prev  = out_rst;
    end

    always @(posedge audio_sck) begin
        rx_shift  <= {rx_shift[30:0], audio_sdin}; // msb first
        sck_edges <= sck_edges + 1;
    end

    // a frame is complete at each lrck fall
    always @(negedge audio_lrck) begin
        synth_pkg::audio_sample_t got;
        synth_pkg::audio_sample_t want;
        logic signed [15:0]       mag;
        logic                     settled;
        got = rx_shift;
        if ((sck_edges - last_edges != 32) && (frame_count > 0)) begin
            other_errors++;
            $display("frame %0d did not carry 32 serial bits", frame_count);
        end
        last_edges = sck_edges;
        settled    = (frame_count >= change_frame + 3); // sample pipeline plus one frame
        if (settled) begin
            mag        = $signed(expected_magnitude(ref_vol));
            want.left  = 16'sd0;
            if (ref_active) begin
                want.left = (got.left < 0) ? -mag : mag;
            end
            want.right = want.left;
            check_sample(got, want);
            if (got.left > 0) pos_seen = 1'b1;
            if (got.left < 0) neg_seen = 1'b1;
            if (prev_settled && (got.left != 0) && (prev_level != 0)
                    && ((got.left < 0) != (prev_level < 0))) begin
                sign_changes++;
            end
        end
        prev_settled = settled;
        prev_level   = got.left;
        frame_count++;
    end

    task automatic send_code(input logic [7:0] code);
        logic [2:0] note;
        logic       known;
        @(posedge clk);
        scan_code  <= code;
        scan_valid <= 1'b1;
        known = is_key(code, note);
        if (code == 8'hF0) begin
            ref_break = 1'b1;
        end else begin
            if (known && ref_break) begin
                if (ref_active && (note == ref_note)) ref_active = 1'b0;
            end else if (known) begin
                ref_active = 1'b1;
                ref_note   = note;
            end
            ref_break = 1'b0;              // prefix covers one byte only
        end
        change_frame = frame_count;
        @(posedge clk);
        scan_valid <= 1'b0;
    endtask

    // 0 vol up, 1 vol down, 2 octave up, 3 octave down
    task automatic press_button(input int which);
        @(posedge clk);
        case (which)
            0: begin
                vol_up <= 1'b1;
                if (ref_vol < 3'd5) ref_vol++;
            end
            1: begin
                vol_down <= 1'b1;
                if (ref_vol > 3'd1) ref_vol--;
            end
            2: begin
                oct_up <= 1'b1;
                if (ref_oct < 3'd5) ref_oct++;
            end
            default: begin
                oct_down <= 1'b1;
                if (ref_oct > 3'd3) ref_oct--;
            end
        endcase
        change_frame = frame_count;
        @(posedge clk);
        vol_up   <= 1'b0;
        vol_down <= 1'b0;
        oct_up   <= 1'b0;
        oct_down <= 1'b0;
        @(negedge clk);
        check_led(led, expected_led(ref_vol));
    endtask

    task automatic check_display();
        seg_view_t  got;
        logic [3:0] seen;
        seen = 4'b0000;
        repeat (4) @(posedge clk);         // command into the display register
        repeat (16) begin
            @(negedge clk);
            got.display = display;
            got.digit   = digit;
            check_segments(got, expected_segments(expected_cmd(), digit));
            seen = seen | ~digit;
        end
        if (ref_active && (seen != 4'b1111)) begin
            other_errors++;
            $display("display scan did not visit all four digits");
        end
    endtask

    task automatic check_pitch();
        int start_changes;
        int start_frame;
        int predicted;
        int counted;
        wait (frame_count >= change_frame + 4);
        start_changes = sign_changes;
        start_frame   = frame_count;
        pos_seen      = 1'b0;
        neg_seen      = 1'b0;
        wait (frame_count >= start_frame + PITCH_FRAMES);
        counted   = sign_changes - start_changes;
        predicted = (PITCH_FRAMES * FRAME_CLKS) / expected_half_period(ref_note, ref_oct);
        if ((counted < predicted - 1) || (counted > predicted + 1)) begin
            sample_errors++;
            $display("[ERROR] %0t: note %0d octave %0d gave %0d sign changes expected %0d",
                     $time, ref_note, ref_oct, counted, predicted);
        end
        if (!(pos_seen && neg_seen)) begin
            other_errors++;
            $display("tone did not swing to both signs within the window");
        end
    endtask

    initial begin
        logic [7:0] code;
        logic [2:0] other;
        void'($urandom(32'hb455));
        out_rst    = 1'b1;
        scan_code  = 8'h00;
        scan_valid = 1'b0;
        vol_up     = 1'b0;
        vol_down   = 1'b0;
        oct_up     = 1'b0;
        oct_down   = 1'b0;
        ref_active = 1'b0;
        ref_note   = 3'd0;
        ref_break  = 1'b0;
        ref_oct    = 3'd4;
        ref_vol    = 3'd3;
        mclk_prev  = 1'b0;
        rst_prev   = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if ({audio_lrck, audio_sck, audio_sdin} != 3'b000) begin
            other_errors++;
            $display("audio serial outputs were not low during reset");
        end
        @(posedge clk);
        out_rst <= 1'b0;
        @(negedge clk);
        check_led(led, expected_led(ref_vol));
        check_display();
        wait (frame_count >= 5);           // a few silent frames

        repeat (24) press_button(int'($urandom_range(0, 1)));

        repeat (3) begin
            press_button(int'($urandom_range(0, 3)));
            if (ref_oct == 3'd5) press_button(3); // keep the half wave above one frame
            send_code(code_of(3'($urandom_range(0, 6))));
            check_display();
            check_pitch();
        end

        repeat (3) press_button(2);        // saturates at 5
        check_display();
        repeat (3) press_button(3);        // saturates at 3
        check_display();

        other = 3'((32'(ref_note) + $urandom_range(1, 6)) % 7);
        send_code(8'hF0);
        send_code(code_of(other));         // release of a key not held
        check_display();
        wait (frame_count >= change_frame + 5);
        do begin
            code = 8'($urandom_range(0, 255));
        end while (is_key(code, other) || (code == 8'hF0));
        send_code(code);
        check_display();
        wait (frame_count >= change_frame + 5);
        send_code(8'hF0);
        send_code(code_of(ref_note));
        check_display();
        wait (frame_count >= change_frame + 6);

        $display("errors: led %0d, sample %0d, display %0d, other %0d",
                 led_errors, sample_errors, segment_errors, other_errors);
        if (led_errors + sample_errors + segment_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
synth_pkg.sv
key_mapper.sv
tone_control.sv
note_gen.sv
speaker_control.sv
seven_segment.sv
music_keyboard_top.sv
tb_music_keyboard.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_music_keyboard \
    -f filelist.f -o tb_music_keyboard
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_music_keyboard)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
